//--- hw/pmp_pkg.sv
`default_nettype none

package pmp_pkg;

  // csr addresses of the first cfg and addr registers.
  localparam logic [11:0] csr_pmpcfg0  = 12'h3a0;
  localparam logic [11:0] csr_pmpaddr0 = 12'h3b0;

  // address matching modes, cfg bits 4:3.
  localparam logic [1:0] a_off   = 2'd0;
  localparam logic [1:0] a_tor   = 2'd1;
  localparam logic [1:0] a_na4   = 2'd2;
  localparam logic [1:0] a_napot = 2'd3;

  localparam logic [1:0] m_mode = 2'd3; // machine privilege.

  // mcause values for access faults.
  localparam logic [3:0] except_instr_access_fault = 4'd1;
  localparam logic [3:0] except_load_access_fault  = 4'd5;
  localparam logic [3:0] except_store_access_fault = 4'd7;

  // csr write word, seen as four cfg bytes or one pmpaddr.
  // byte 0 sits in bits 7:0.
  typedef union packed {
    logic [3:0][7:0] cfg_bytes;
    logic [31:0]     addr_word;
  } pmp_csr_word_t;

endpackage

`default_nettype wire

//--- hw/pmp_region_match.sv
`default_nettype none

module pmp_region_match (
  input  logic [1:0]  a,
  input  logic [31:0] addr_lo,
  input  logic [31:0] addr_cur,
  input  logic [31:0] mem_addr,
  output logic        hit
);
  import pmp_pkg::*;

  logic [33:0] tor_lo;
  logic [33:0] tor_hi;     // exclusive bound.
  logic [33:0] byte_addr;
  logic [31:0] word_addr;
  logic [31:0] napot_mask;

  // pmpaddr holds address bits 33:2, so compare on 34 bits.
  assign tor_lo    = {addr_lo, 2'b00};
  assign tor_hi    = {addr_cur, 2'b00};
  assign byte_addr = {2'b00, mem_addr};
  assign word_addr = {2'b00, mem_addr[31:2]};

  // trailing ones and the zero above them are don't care.
  assign napot_mask = ~(addr_cur ^ (addr_cur + 32'd1));

  always_comb begin
    case (a)
      // lo >= hi gives an empty range, never a hit.
      a_tor:   hit = (byte_addr >= tor_lo) && (byte_addr < tor_hi);
      a_na4:   hit = (word_addr == addr_cur);
      a_napot: hit = ((word_addr ^ addr_cur) & napot_mask) == 32'd0;
      default: hit = 1'b0; // off.
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pmp_checker.sv
`default_nettype none

module pmp_checker #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                          mem_valid,
  input  logic                          mem_instr,
  input  logic [3:0]                    mem_wstrb,
  input  logic [31:0]                   mem_addr,
  input  logic [1:0]                    mode,
  input  logic [NUM_REGIONS-1:0]        cfg_l,
  input  logic [NUM_REGIONS-1:0][1:0]   cfg_a,
  input  logic [NUM_REGIONS-1:0]        cfg_x,
  input  logic [NUM_REGIONS-1:0]        cfg_w,
  input  logic [NUM_REGIONS-1:0]        cfg_r,
  input  logic [NUM_REGIONS-1:0][31:0]  addr,
  output logic                          exception,
  output logic [3:0]                    ecause,
  output logic [31:0]                   etval
);
  import pmp_pkg::*;

  logic                   is_write;
  logic                   is_m;
  logic [NUM_REGIONS-1:0] hit;
  logic [NUM_REGIONS-1:0] region_ok;
  logic                   allow;

  assign is_write = ~mem_instr & (|mem_wstrb);
  assign is_m     = (mode == m_mode);

  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_region
    logic [31:0] lo;
    if (g == 0) begin : g_first
      assign lo = '0; // tor of region 0 starts at 0.
    end else begin : g_rest
      assign lo = addr[g-1];
    end

    pmp_region_match match_i (
      .a        (cfg_a[g]),
      .addr_lo  (lo),
      .addr_cur (addr[g]),
      .mem_addr (mem_addr),
      .hit      (hit[g])
    );

    // locked entries bind machine mode too.
    assign region_ok[g] = (mem_instr ? cfg_x[g] : (is_write ? cfg_w[g] : cfg_r[g]))
                        | (is_m & ~cfg_l[g]);
  end

  // scan downwards so the lowest hit is applied last.
  always_comb begin
    allow = is_m;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        allow = region_ok[i];
      end
    end
  end

  assign exception = mem_valid & ~allow;
  assign etval     = exception ? mem_addr : '0;

  always_comb begin
    ecause = '0;
    if (exception) begin
      if (mem_instr)     ecause = except_instr_access_fault;
      else if (is_write) ecause = except_store_access_fault;
      else               ecause = except_load_access_fault;
    end
  end

endmodule

`default_nettype wire

//--- hw/pmp_csr_file.sv
`default_nettype none

module pmp_csr_file #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cwren,
  input  logic [11:0]                   cwaddr,
  input  pmp_pkg::pmp_csr_word_t        cwdata,
  input  logic                          crden,
  input  logic [11:0]                   craddr,
  output logic [31:0]                   crdata,
  output logic [NUM_REGIONS-1:0]        cfg_l,
  output logic [NUM_REGIONS-1:0][1:0]   cfg_a,
  output logic [NUM_REGIONS-1:0]        cfg_x,
  output logic [NUM_REGIONS-1:0]        cfg_w,
  output logic [NUM_REGIONS-1:0]        cfg_r,
  output logic [NUM_REGIONS-1:0][31:0]  addr
);
  import pmp_pkg::*;

  logic [NUM_REGIONS-1:0] addr_locked;

  // pmpaddr i is frozen by its own lock or by a locked tor entry above it.
  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_lock
    if (g == NUM_REGIONS - 1) begin : g_last
      assign addr_locked[g] = cfg_l[g];
    end else begin : g_mid
      assign addr_locked[g] = cfg_l[g] | (cfg_l[g+1] & (cfg_a[g+1] == a_tor));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      cfg_l <= '0;
      cfg_a <= '0;
      cfg_x <= '0;
      cfg_w <= '0;
      cfg_r <= '0;
      addr  <= '0;
    end else if (cwren) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        // four regions per cfg csr.
        if (cwaddr == csr_pmpcfg0 + 12'(i / 4) && !cfg_l[i]) begin
          cfg_l[i] <= cwdata.cfg_bytes[i % 4][7];
          cfg_a[i] <= cwdata.cfg_bytes[i % 4][4:3];
          cfg_x[i] <= cwdata.cfg_bytes[i % 4][2];
          cfg_w[i] <= cwdata.cfg_bytes[i % 4][1];
          cfg_r[i] <= cwdata.cfg_bytes[i % 4][0];
        end
        if (cwaddr == csr_pmpaddr0 + 12'(i) && !addr_locked[i]) begin
          addr[i] <= cwdata.addr_word;
        end
      end
    end
  end

  // read port, zero for anything outside the pmp range.
  always_comb begin
    crdata = '0;
    if (crden) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (craddr == csr_pmpcfg0 + 12'(i / 4)) begin
          crdata[8*(i%4) +: 8] = {cfg_l[i], 2'b00, cfg_a[i], cfg_x[i], cfg_w[i], cfg_r[i]};
        end
        if (craddr == csr_pmpaddr0 + 12'(i)) begin
          crdata = addr[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/pmp_unit.sv
`default_nettype none

module pmp_unit #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cwren,
  input  logic [11:0]            cwaddr,
  input  pmp_pkg::pmp_csr_word_t cwdata,
  input  logic                   crden,
  input  logic [11:0]            craddr,
  output logic [31:0]            crdata,
  input  logic                   mem_valid,
  input  logic                   mem_instr,
  input  logic [3:0]             mem_wstrb,
  input  logic [31:0]            mem_addr,
  input  logic [1:0]             mode,
  output logic                   exception,
  output logic [3:0]             ecause,
  output logic [31:0]            etval
);

  // register contents seen by the checker.
  logic [NUM_REGIONS-1:0]        cfg_l;
  logic [NUM_REGIONS-1:0][1:0]   cfg_a;
  logic [NUM_REGIONS-1:0]        cfg_x;
  logic [NUM_REGIONS-1:0]        cfg_w;
  logic [NUM_REGIONS-1:0]        cfg_r;
  logic [NUM_REGIONS-1:0][31:0]  addr;

  pmp_csr_file #(.NUM_REGIONS(NUM_REGIONS)) csr_i (
    .clk    (clk),
    .rst    (rst),
    .cwren  (cwren),
    .cwaddr (cwaddr),
    .cwdata (cwdata),
    .crden  (crden),
    .craddr (craddr),
    .crdata (crdata),
    .cfg_l  (cfg_l),
    .cfg_a  (cfg_a),
    .cfg_x  (cfg_x),
    .cfg_w  (cfg_w),
    .cfg_r  (cfg_r),
    .addr   (addr)
  );

  pmp_checker #(.NUM_REGIONS(NUM_REGIONS)) checker_i (
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_wstrb (mem_wstrb),
    .mem_addr  (mem_addr),
    .mode      (mode),
    .cfg_l     (cfg_l),
    .cfg_a     (cfg_a),
    .cfg_x     (cfg_x),
    .cfg_w     (cfg_w),
    .cfg_r     (cfg_r),
    .addr      (addr),
    .exception (exception),
    .ecause    (ecause),
    .etval     (etval)
  );

endmodule

`default_nettype wire

//--- sim/pmp_clock_gen.sv
`default_nettype none

module pmp_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1; // released after two edges.
  end

  always #20 clk = ~clk;

endmodule

`default_nettype wire

//--- sim/pmp_properties.sv
`default_nettype none

module pmp_properties (
  input logic        clk,
  input logic        rst,
  input logic        mem_valid,
  input logic [31:0] mem_addr,
  input logic        exception,
  input logic [3:0]  ecause,
  input logic [31:0] etval,
  input logic        crden,
  input logic [31:0] crdata
);

  exc_needs_valid: assert property (@(posedge clk) disable iff (!rst)
    exception |-> mem_valid)
    else $error("exception raised while mem_valid is low");

  cause_with_exc: assert property (@(posedge clk) disable iff (!rst)
    (ecause != 4'd0) == exception)
    else $error("ecause and exception disagree");

  tval_is_addr: assert property (@(posedge clk) disable iff (!rst)
    exception |-> (etval == mem_addr))
    else $error("etval differs from mem_addr on a fault");

  // read port idles at zero.
  rdata_idle: assert property (@(posedge clk) disable iff (!rst)
    !crden |-> (crdata == 32'd0))
    else $error("crdata nonzero while crden is low");

endmodule

bind pmp_unit pmp_properties props_i (
  .clk       (clk),
  .rst       (rst),
  .mem_valid (mem_valid),
  .mem_addr  (mem_addr),
  .exception (exception),
  .ecause    (ecause),
  .etval     (etval),
  .crden     (crden),
  .crdata    (crdata)
);

`default_nettype wire

//--- include/pmp_tb_model.svh
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

localparam int mdl_regions = 8;

logic [7:0]  mdl_cfg  [mdl_regions]; // bits 6:5 kept at zero.
logic [31:0] mdl_addr [mdl_regions];

function automatic void clear_model();
  for (int i = 0; i < mdl_regions; i++) begin
    mdl_cfg[i]  = 8'h00;
    mdl_addr[i] = 32'h0;
  end
endfunction

function automatic bit addr_write_blocked(int i);
  if (mdl_cfg[i][7]) return 1'b1;
  if (i + 1 < mdl_regions) return mdl_cfg[i+1][7] && mdl_cfg[i+1][4:3] == pmp_pkg::a_tor;
  return 1'b0;
endfunction

function automatic void apply_csr_write(logic [11:0] a, logic [31:0] d);
  for (int i = 0; i < mdl_regions; i++) begin
    if (a == pmp_pkg::csr_pmpcfg0 + 12'(i / 4) && !mdl_cfg[i][7]) begin
      mdl_cfg[i] = d[8*(i%4) +: 8] & 8'h9f;
    end
    if (a == pmp_pkg::csr_pmpaddr0 + 12'(i) && !addr_write_blocked(i)) begin
      mdl_addr[i] = d;
    end
  end
endfunction

function automatic logic [31:0] expected_read(logic [11:0] a);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < mdl_regions; i++) begin
    if (a == pmp_pkg::csr_pmpcfg0 + 12'(i / 4)) r[8*(i%4) +: 8] = mdl_cfg[i];
    if (a == pmp_pkg::csr_pmpaddr0 + 12'(i)) r = mdl_addr[i];
  end
  return r;
endfunction

function automatic bit region_contains(int i, logic [31:0] ma);
  logic [33:0] lo;
  logic [33:0] hi;
  logic [33:0] mask;
  int          t;
  lo = '0;
  if (i > 0) lo = {mdl_addr[i-1], 2'b00};
  hi = {mdl_addr[i], 2'b00};
  case (mdl_cfg[i][4:3])
    pmp_pkg::a_tor: return {2'b00, ma} >= lo && {2'b00, ma} < hi;
    pmp_pkg::a_na4: return ma[31:2] == mdl_addr[i][29:0] && mdl_addr[i][31:30] == 2'b00;
    pmp_pkg::a_napot: begin
      t = 0;
      while (t < 32 && mdl_addr[i][t]) t++;
      mask = ~((34'd1 << (t + 1)) - 34'd1);
      return (({4'b0000, ma[31:2]} ^ {2'b00, mdl_addr[i]}) & mask) == '0;
    end
    default: return 1'b0;
  endcase
endfunction

// lowest matching region decides, machine mode passes on no match.
function automatic void expected_access(input bit valid, input bit instr,
                                        input logic [3:0] wstrb,
                                        input logic [31:0] ma, input logic [1:0] mode,
                                        output bit exc, output logic [3:0] cause,
                                        output logic [31:0] tval);
  bit         found;
  bit         ok;
  logic [7:0] c;
  found = 1'b0;
  ok = (mode == pmp_pkg::m_mode);
  for (int i = 0; i < mdl_regions && !found; i++) begin
    c = mdl_cfg[i];
    if (region_contains(i, ma)) begin
      found = 1'b1;
      ok = (instr ? c[2] : (|wstrb ? c[1] : c[0])) || (mode == pmp_pkg::m_mode && !c[7]);
    end
  end
  exc = valid && !ok;
  cause = 4'd0;
  if (exc) begin
    if (instr)       cause = pmp_pkg::except_instr_access_fault;
    else if (|wstrb) cause = pmp_pkg::except_store_access_fault;
    else             cause = pmp_pkg::except_load_access_fault;
  end
  tval = exc ? ma : 32'd0;
endfunction

`endif

//--- sim/pmp_tb.sv
`default_nettype none

module pmp_tb;
  import pmp_pkg::*;

  `include "pmp_tb_model.svh"

  logic          clk;
  logic          rst;
  logic          cwren;
  logic [11:0]   cwaddr;
  pmp_csr_word_t cwdata;
  logic          crden;
  logic [11:0]   craddr;
  logic [31:0]   crdata;
  logic          mem_valid;
  logic          mem_instr;
  logic [3:0]    mem_wstrb;
  logic [31:0]   mem_addr;
  logic [1:0]    mode;
  logic          exception;
  logic [3:0]    ecause;
  logic [31:0]   etval;
  logic [31:0]   seed;
  int            errors;
  int            timeouts;

  pmp_clock_gen clk_gen_i (.clk(clk), .rst(rst));

  pmp_unit #(.NUM_REGIONS(8)) dut_i (
    .clk       (clk),
    .rst       (rst),
    .cwren     (cwren),
    .cwaddr    (cwaddr),
    .cwdata    (cwdata),
    .crden     (crden),
    .craddr    (craddr),
    .crdata    (crdata),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_wstrb (mem_wstrb),
    .mem_addr  (mem_addr),
    .mode      (mode),
    .exception (exception),
    .ecause    (ecause),
    .etval     (etval)
  );

  function automatic logic [31:0] next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!rst) begin
      $display("timeout: reset was still asserted after 10 cycles");
      timeouts++;
    end
  endtask

  // model follows once the dut has taken the write.
  task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    @(posedge clk);
    cwren  <= 1'b1;
    cwaddr <= a;
    cwdata <= d;
    @(posedge clk);
    cwren <= 1'b0;
    apply_csr_write(a, d);
  endtask

  task automatic check_read(input string name, input logic [11:0] a);
    @(posedge clk);
    crden  <= 1'b1;
    craddr <= a;
    @(negedge clk);
    compare_word(name, expected_read(a), crdata);
  endtask

  task automatic check_access(input string name, input bit valid, input bit instr,
                              input logic [3:0] wstrb, input logic [31:0] ma,
                              input logic [1:0] md);
    bit          exp_exc;
    logic [3:0]  exp_cause;
    logic [31:0] exp_tval;
    @(posedge clk);
    crden     <= 1'b0;
    mem_valid <= valid;
    mem_instr <= instr;
    mem_wstrb <= wstrb;
    mem_addr  <= ma;
    mode      <= md;
    @(negedge clk);
    expected_access(valid, instr, wstrb, ma, md, exp_exc, exp_cause, exp_tval);
    compare_word({name, " exception"}, 32'(exp_exc), 32'(exception));
    compare_word({name, " ecause"}, 32'(exp_cause), 32'(ecause));
    compare_word({name, " etval"}, exp_tval, etval);
  endtask

  task automatic random_access(input string name);
    logic [31:0] r;
    r = next_rand();
    check_access(name, r[0] | r[3], r[1], r[2] ? r[7:4] : 4'h0, next_rand() & 32'hff, r[9:8]);
  endtask

  // small address window so that regions overlap the accesses.
  task automatic random_regions(input bit allow_lock);
    logic [31:0] d;
    for (int i = 0; i < 8; i++) write_csr(csr_pmpaddr0 + 12'(i), next_rand() & 32'h3f);
    for (int i = 0; i < 2; i++) begin
      d = next_rand();
      if (!allow_lock) d = d & 32'h7f7f_7f7f;
      write_csr(csr_pmpcfg0 + 12'(i), d);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [11:0] a;
    seed      = 32'ha49a_1614;
    errors    = 0;
    timeouts  = 0;
    cwren     = 1'b0;
    cwaddr    = '0;
    cwdata    = '0;
    crden     = 1'b0;
    craddr    = '0;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_wstrb = '0;
    mem_addr  = '0;
    mode      = '0;
    clear_model();
    wait_reset_release();
    if (timeouts == 0) begin
      for (int i = 0; i < 2; i++) check_read("reset cfg", csr_pmpcfg0 + 12'(i));
      for (int i = 0; i < 8; i++) check_read("reset addr", csr_pmpaddr0 + 12'(i));
      check_access("reset u-mode", 1'b1, 1'b0, 4'h0, 32'h40, 2'd0);
      check_access("reset s-mode", 1'b1, 1'b0, 4'hf, 32'h44, 2'd1);
      check_access("reset m-mode", 1'b1, 1'b1, 4'h0, 32'h48, m_mode);
      repeat (60) begin
        r = next_rand();
        a = r[3] ? csr_pmpcfg0 + 12'(r[0]) : csr_pmpaddr0 + 12'(r[2:0]);
        if (r[7:4] == 4'h0) a = 12'h3c0; // outside the pmp range.
        write_csr(a, r[3] ? next_rand() & 32'h7f7f_7f7f : next_rand() & 32'h3f);
        check_read("csr readback", a);
        if (r[3]) compare_word("cfg bits 6:5", 32'h0, crdata & 32'h6060_6060);
      end
      check_read("non-pmp 3a2", 12'h3a2);
      compare_word("non-pmp 3a2", 32'h0, crdata);
      check_read("non-pmp 3b8", 12'h3b8);
      compare_word("non-pmp 3b8", 32'h0, crdata);
      check_read("non-pmp 300", 12'h300);
      compare_word("non-pmp 300", 32'h0, crdata);
      repeat (10) begin
        random_regions(1'b0);
        repeat (30) random_access("random access");
      end
      repeat (20) begin
        r = next_rand();
        check_access("valid low", 1'b0, r[0], r[7:4], next_rand() & 32'hff, r[9:8]);
        compare_word("valid low etval", 32'h0, etval);
      end
      write_csr(csr_pmpcfg0, 32'h0);
      write_csr(csr_pmpcfg0 + 12'd1, 32'h0);
      write_csr(csr_pmpaddr0, 32'h10);
      write_csr(csr_pmpaddr0 + 12'd1, 32'h20);
      write_csr(csr_pmpaddr0 + 12'd2, 32'h30);
      write_csr(csr_pmpaddr0 + 12'd3, 32'h38);
      // locked na4, open na4, off, locked tor with r.
      write_csr(csr_pmpcfg0, 32'h8900_1090);
      check_access("m-mode locked", 1'b1, 1'b0, 4'h0, 32'h40, m_mode);
      compare_word("m-mode locked fault", 32'h1, 32'(exception));
      check_access("m-mode unlocked", 1'b1, 1'b0, 4'h0, 32'h80, m_mode);
      compare_word("m-mode unlocked pass", 32'h0, 32'(exception));
      write_csr(csr_pmpcfg0, 32'h0);
      check_read("locked cfg", csr_pmpcfg0);
      compare_word("locked cfg bytes", 32'h8900_0090, crdata);
      write_csr(csr_pmpaddr0, 32'h55);
      check_read("own lock addr", csr_pmpaddr0);
      compare_word("own lock addr", 32'h10, crdata);
      write_csr(csr_pmpaddr0 + 12'd2, 32'h55);
      check_read("tor lock addr", csr_pmpaddr0 + 12'd2);
      compare_word("tor lock addr", 32'h30, crdata);
      write_csr(csr_pmpaddr0 + 12'd1, 32'h21);
      check_read("open addr", csr_pmpaddr0 + 12'd1);
      compare_word("open addr", 32'h21, crdata);
      repeat (6) begin
        random_regions(1'b1);
        for (int i = 0; i < 2; i++) check_read("locked readback", csr_pmpcfg0 + 12'(i));
        for (int i = 0; i < 8; i++) check_read("locked readback", csr_pmpaddr0 + 12'(i));
        repeat (20) random_access("locked access");
      end
    end
    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/pmp_pkg.sv
hw/pmp_region_match.sv
hw/pmp_checker.sv
hw/pmp_csr_file.sv
hw/pmp_unit.sv
sim/pmp_clock_gen.sv
sim/pmp_properties.sv
sim/pmp_tb.sv
